// File: flist.f
mem_pkg.sv
arb_pkg.sv
line_arbiter.sv
burst_reader.sv
burst_writer.sv
line_mem_ctrl.sv
tb_mem_model.sv
tb_line_mem_ctrl.sv

// File: Makefile
SIM     = verilator
FLAGS   = --binary --timing
TOP     = tb_line_mem_ctrl
FLIST   = flist.f

OBJ_DIR = obj_dir
SIM_BIN = $(OBJ_DIR)/V$(TOP)
LOG     = sim.log
SOURCES = $(shell cat $(FLIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_line_mem_ctrl.sv
`timescale 1ns/1ps

module tb_line_mem_ctrl;
    import mem_pkg::*;
    import arb_pkg::*;

    localparam int reset_cycles  = 10;
    localparam int quiet_cycles  = 20;
    // preloads and idle gaps between tests
    localparam int setup_cycles  = 40;
    // reads and writes over all tests
    localparam int txn_count     = 14;
    // worst transaction, a write under long stall
    localparam int txn_budget    = 120;
    localparam int timeout_cycles =
        reset_cycles + quiet_cycles + setup_cycles + txn_count * txn_budget;

    logic                           clk;
    logic                           rst;
    logic [num_req-1:0]             req_read;
    logic [num_req-1:0]             req_write;
    logic [num_req-1:0][addr_w-1:0] req_addr;
    logic [num_req-1:0][line_w-1:0] req_wdata;
    logic [num_req-1:0]             resp;
    logic [num_req-1:0][line_w-1:0] rdata;
    logic [addr_w-1:0]              mem_addr;
    logic                           mem_read;
    logic                           mem_write;
    logic [beat_w-1:0]              mem_wdata;
    logic                           mem_ready;
    logic                           mem_rvalid;
    logic [beat_w-1:0]              mem_rdata;
    logic                           long_stall;
    logic                           load_en;
    logic [addr_w-1:0]              load_addr;
    logic [line_w-1:0]              load_line;
    int                             read_cmds;
    int                             write_beats;
    logic [line_w-1:0]              last_wline;
    int                             cycles;

    line_mem_ctrl DUT (
        .clk       (clk),
        .rst       (rst),
        .req_read  (req_read),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .resp      (resp),
        .rdata     (rdata),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_ready (mem_ready),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata)
    );

    tb_mem_model u_mem (
        .clk        (clk),
        .rst        (rst),
        .mem_addr   (mem_addr),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_wdata  (mem_wdata),
        .mem_ready  (mem_ready),
        .mem_rvalid (mem_rvalid),
        .mem_rdata  (mem_rdata),
        .long_stall (long_stall),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_line  (load_line),
        .read_cmds  (read_cmds),
        .write_beats(write_beats),
        .last_wline (last_wline)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    initial begin
        cycles = 0;
        while (cycles < timeout_cycles) begin
            @(posedge clk);
            cycles++;
        end
        stop_run($sformatf("timeout, run did not finish within %0d cycles", timeout_cycles));
    end

    task automatic check_line(input string name, input logic [line_w-1:0] got,
                              input logic [line_w-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_resp(input string name, input logic [num_req-1:0] got,
                              input logic [num_req-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_run($sformatf("FAIL %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // distinct beats per slot so a swapped beat shows up
    function automatic logic [line_w-1:0] make_line(input int tag);
        logic [line_w-1:0] l;
        for (int b = 0; b < beats_per_line; b++) begin
            l[b*beat_w +: beat_w] = {tag[15:0], 16'(b), 32'hc0de_0000 ^ tag};
        end
        return l;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic preload(input logic [addr_w-1:0] addr, input logic [line_w-1:0] l);
        load_en   = 1'b1;
        load_addr = addr;
        load_line = l;
        step();
        load_en = 1'b0;
    endtask

    // returns at the falling edge of the resp cycle
    task automatic wait_resp(input req_id_t id);
        logic [num_req-1:0] exp;
        exp     = '0;
        exp[id] = 1'b1;
        do begin
            @(negedge clk);
        end while (resp == '0);
        check_resp("resp", resp, exp);
    endtask

    task automatic do_read(input req_id_t id, input logic [addr_w-1:0] addr,
                           input logic [line_w-1:0] exp);
        int cmds_before;
        cmds_before   = read_cmds;
        req_read[id]  = 1'b1;
        req_addr[id]  = addr;
        wait_resp(id);
        check_line("rdata", rdata[id], exp);
        // one read command per line
        check_count("read_cmds", read_cmds - cmds_before, 1);
        step();
        req_read[id] = 1'b0;
    endtask

    task automatic do_write(input req_id_t id, input logic [addr_w-1:0] addr,
                            input logic [line_w-1:0] l);
        int beats_before;
        beats_before  = write_beats;
        req_write[id] = 1'b1;
        req_addr[id]  = addr;
        req_wdata[id] = l;
        wait_resp(id);
        check_count("write_beats", write_beats - beats_before, beats_per_line);
        // model rebuilt the line from beats in arrival order
        check_line("last_wline", last_wline, l);
        step();
        req_write[id] = 1'b0;
    endtask

    task automatic test_quiet_after_reset();
        apply_reset();
        for (int n = 0; n < quiet_cycles; n++) begin
            @(negedge clk);
            check_bit("mem_read", mem_read, 1'b0);
            check_bit("mem_write", mem_write, 1'b0);
            check_resp("resp", resp, '0);
        end
        step();
    endtask

    task automatic test_read_each();
        req_id_t ids[4];
        ids = '{ooo_icache, ooo_dcache, ppl_icache, ppl_dcache};
        preload(32'h0000_1000, make_line(100));
        for (int k = 0; k < num_req; k++) begin
            do_read(ids[k], 32'h0000_1000, make_line(100));
        end
    endtask

    task automatic test_write_then_read();
        do_write(ooo_dcache, 32'h0000_2040, make_line(200));
        do_read(ppl_dcache, 32'h0000_2040, make_line(200));
    endtask

    task automatic test_round_robin();
        req_id_t           order[5];
        logic [addr_w-1:0] base;
        order = '{ooo_icache, ooo_dcache, ppl_icache, ppl_dcache, ooo_icache};
        base  = 32'h0000_3000;
        for (int k = 0; k < 6; k++) begin
            preload(base + k * 32, make_line(300 + k));
        end
        // last served is requester 3, so polling resumes at 0
        do_read(ppl_dcache, base + 5 * 32, make_line(305));
        for (int k = 0; k < num_req; k++) begin
            req_read[order[k]] = 1'b1;
            req_addr[order[k]] = base + k * 32;
        end
        for (int k = 0; k < 5; k++) begin
            wait_resp(order[k]);
            check_line("rdata", rdata[order[k]], make_line(300 + k));
            step();
            if (k == 0) begin
                // requester 0 asks again right away
                req_addr[ooo_icache] = base + 4 * 32;
            end else begin
                req_read[order[k]] = 1'b0;
            end
        end
    endtask

    task automatic test_back_pressure();
        long_stall = 1'b1;
        do_write(ppl_dcache, 32'h0000_4080, make_line(400));
        do_read(ooo_dcache, 32'h0000_4080, make_line(400));
        long_stall = 1'b0;
    endtask

    initial begin
        rst        = 1'b1;
        req_read   = '0;
        req_write  = '0;
        req_addr   = '0;
        req_wdata  = '0;
        long_stall = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_line  = '0;
        test_quiet_after_reset();
        test_read_each();
        test_write_then_read();
        test_round_robin();
        test_back_pressure();
        $display("TEST OK");
        $finish;
    end

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model (
    input  logic                       clk,
    input  logic                       rst,
    input  logic [mem_pkg::addr_w-1:0] mem_addr,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  logic [mem_pkg::beat_w-1:0] mem_wdata,
    output logic                       mem_ready,
    output logic                       mem_rvalid,
    output logic [mem_pkg::beat_w-1:0] mem_rdata,
    // testbench control and observation
    input  logic                       long_stall,
    input  logic                       load_en,
    input  logic [mem_pkg::addr_w-1:0] load_addr,
    input  logic [mem_pkg::line_w-1:0] load_line,
    output int                         read_cmds,
    output int                         write_beats,
    output logic [mem_pkg::line_w-1:0] last_wline
);
    import mem_pkg::*;

    // cycles from read command to first possible beat
    localparam int read_latency = 3;
    // ready comes up once per this many cycles in long stall mode
    localparam int stall_len = 20;

    // sparse line store keyed by line address
    logic [line_w-1:0] store [logic [addr_w-1:0]];

    logic [31:0]       lcg;
    int                stall_cnt;
    logic              rd_busy;
    int                rd_wait;
    beat_cnt_t         rd_beat;
    logic [line_w-1:0] rd_line;
    beat_cnt_t         wr_beat;
    logic [line_w-1:0] wline;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [addr_w-1:0] line_addr(input logic [addr_w-1:0] a);
        return {a[addr_w-1:line_offset_w], {line_offset_w{1'b0}}};
    endfunction

    // untouched lines read back a pattern built from the address
    function automatic logic [line_w-1:0] line_at(input logic [addr_w-1:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        return {4{~a, a}};
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            lcg         <= 32'd89742;
            stall_cnt   <= 0;
            mem_ready   <= 1'b0;
            mem_rvalid  <= 1'b0;
            mem_rdata   <= '0;
            rd_busy     <= 1'b0;
            rd_wait     <= 0;
            rd_beat     <= '0;
            wr_beat     <= '0;
            read_cmds   <= 0;
            write_beats <= 0;
        end else begin
            lcg <= next_rand(lcg);
            if (long_stall) begin
                mem_ready <= (stall_cnt == 0);
                stall_cnt <= (stall_cnt == 0) ? stall_len - 1 : stall_cnt - 1;
            end else begin
                // ready about three cycles out of four
                mem_ready <= (lcg[17:16] != 2'b00);
            end
            if (load_en) begin
                store[line_addr(load_addr)] = load_line;
            end
            // read command taken, line fetched once
            if (mem_read && mem_ready) begin
                read_cmds <= read_cmds + 1;
                rd_busy   <= 1'b1;
                rd_wait   <= read_latency;
                rd_beat   <= '0;
                rd_line   <= line_at(line_addr(mem_addr));
            end
            mem_rvalid <= 1'b0;
            if (rd_busy) begin
                if (rd_wait != 0) begin
                    rd_wait <= rd_wait - 1;
                end else if (lcg[20] == 1'b0) begin
                    // beat out, otherwise a gap this cycle
                    mem_rvalid <= 1'b1;
                    mem_rdata  <= rd_line[rd_beat*beat_w +: beat_w];
                    rd_beat    <= rd_beat + 1'b1;
                    if (rd_beat == 2'd3) begin
                        rd_busy <= 1'b0;
                    end
                end
            end
            // write beats fill the line slot by slot, lowest first
            if (mem_write && mem_ready) begin
                write_beats <= write_beats + 1;
                wline[wr_beat*beat_w +: beat_w] <= mem_wdata;
                wr_beat <= wr_beat + 1'b1;
                if (wr_beat == 2'd3) begin
                    store[line_addr(mem_addr)] = {mem_wdata, wline[3*beat_w-1:0]};
                    last_wline <= {mem_wdata, wline[3*beat_w-1:0]};
                end
            end
        end
    end

endmodule

// File: line_mem_ctrl.sv
`timescale 1ns/1ps

module line_mem_ctrl (
    input  logic                                            clk,
    input  logic                                            rst,

    // requester side, indexed by requester number
    input  logic [arb_pkg::num_req-1:0]                     req_read,
    input  logic [arb_pkg::num_req-1:0]                     req_write,
    input  logic [arb_pkg::num_req-1:0][mem_pkg::addr_w-1:0] req_addr,
    input  logic [arb_pkg::num_req-1:0][mem_pkg::line_w-1:0] req_wdata,
    output logic [arb_pkg::num_req-1:0]                     resp,
    output logic [arb_pkg::num_req-1:0][mem_pkg::line_w-1:0] rdata,

    // burst memory side
    output logic [mem_pkg::addr_w-1:0]                      mem_addr,
    output logic                                            mem_read,
    output logic                                            mem_write,
    output logic [mem_pkg::beat_w-1:0]                      mem_wdata,
    input  logic                                            mem_ready,
    input  logic                                            mem_rvalid,
    input  logic [mem_pkg::beat_w-1:0]                      mem_rdata
);
    import mem_pkg::*;

    logic              start_read;
    logic              start_write;
    logic [addr_w-1:0] sel_addr;
    logic [line_w-1:0] sel_wdata;
    logic              read_done;
    logic              write_done;
    logic [line_w-1:0] fill_line;

    // per-engine command addresses
    logic [addr_w-1:0] mem_raddr;
    logic [addr_w-1:0] mem_waddr;

    line_arbiter u_arbiter (
        .clk        (clk),
        .rst        (rst),
        .req_read   (req_read),
        .req_write  (req_write),
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .read_done  (read_done),
        .write_done (write_done),
        .fill_line  (fill_line),
        .start_read (start_read),
        .start_write(start_write),
        .sel_addr   (sel_addr),
        .sel_wdata  (sel_wdata),
        .resp       (resp),
        .rdata      (rdata)
    );

    burst_reader u_reader (
        .clk       (clk),
        .rst       (rst),
        .start_read(start_read),
        .addr      (sel_addr),
        .mem_ready (mem_ready),
        .mem_rvalid(mem_rvalid),
        .mem_rdata (mem_rdata),
        .mem_read  (mem_read),
        .mem_raddr (mem_raddr),
        .fill_line (fill_line),
        .read_done (read_done)
    );

    burst_writer u_writer (
        .clk        (clk),
        .rst        (rst),
        .start_write(start_write),
        .addr       (sel_addr),
        .line       (sel_wdata),
        .mem_ready  (mem_ready),
        .mem_write  (mem_write),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .write_done (write_done)
    );

    // only one engine is ever active
    assign mem_addr = mem_write ? mem_waddr : mem_raddr;

endmodule

// File: burst_writer.sv
`timescale 1ns/1ps

module burst_writer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_write,
    input  logic [mem_pkg::addr_w-1:0] addr,
    input  logic [mem_pkg::line_w-1:0] line,
    input  logic                       mem_ready,
    output logic                       mem_write,
    output logic [mem_pkg::addr_w-1:0] mem_waddr,
    output logic [mem_pkg::beat_w-1:0] mem_wdata,
    output logic                       write_done
);
    import mem_pkg::*;

    // local copy of the line being written
    logic [line_w-1:0] line_q;

    // beat currently on the bus
    beat_cnt_t         beat_cnt;
    logic              last_beat;
    logic              beat_taken;

    assign last_beat  = (beat_cnt == beat_cnt_t'(beats_per_line - 1));
    assign beat_taken = mem_write & mem_ready;

    // present beat follows the counter
    assign mem_wdata = line_q[beat_cnt*beat_w +: beat_w];

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_write  <= 1'b0;
            beat_cnt   <= '0;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            if (start_write) begin
                // beat 0 goes out next cycle
                mem_write <= 1'b1;
                beat_cnt  <= '0;
            end else if (beat_taken) begin
                if (last_beat) begin
                    mem_write  <= 1'b0;
                    write_done <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end
            // without ready the same beat just stays up
        end
    end

    // capture address and line at launch
    // same line address on every beat
    always_ff @(posedge clk) begin
        if (start_write) begin
            mem_waddr <= {addr[addr_w-1:line_offset_w], {line_offset_w{1'b0}}};
            line_q    <= line;
        end
    end

endmodule

// File: burst_reader.sv
`timescale 1ns/1ps

module burst_reader (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start_read,
    input  logic [mem_pkg::addr_w-1:0] addr,
    input  logic                       mem_ready,
    input  logic                       mem_rvalid,
    input  logic [mem_pkg::beat_w-1:0] mem_rdata,
    output logic                       mem_read,
    output logic [mem_pkg::addr_w-1:0] mem_raddr,
    output logic [mem_pkg::line_w-1:0] fill_line,
    output logic                       read_done
);
    import mem_pkg::*;

    // waiting for read beats
    logic      busy;
    beat_cnt_t beat_cnt;
    logic      last_beat;

    assign last_beat = (beat_cnt == beat_cnt_t'(beats_per_line - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            mem_read  <= 1'b0;
            busy      <= 1'b0;
            beat_cnt  <= '0;
            read_done <= 1'b0;
        end else begin
            read_done <= 1'b0;
            if (start_read) begin
                // one command per line, held until memory takes it
                mem_read <= 1'b1;
                busy     <= 1'b1;
                beat_cnt <= '0;
            end else if (mem_read && mem_ready) begin
                mem_read <= 1'b0;
            end
            // beats come in order, lowest first
            if (busy && mem_rvalid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    busy      <= 1'b0;
                    read_done <= 1'b1;
                end
            end
        end
    end

    // address and line storage
    always_ff @(posedge clk) begin
        if (start_read) begin
            mem_raddr <= {addr[addr_w-1:line_offset_w], {line_offset_w{1'b0}}};
        end
        if (busy && mem_rvalid) begin
            fill_line[beat_cnt*beat_w +: beat_w] <= mem_rdata;
        end
    end

endmodule

// File: line_arbiter.sv
`timescale 1ns/1ps

module line_arbiter (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [arb_pkg::num_req-1:0]                     req_read,
    input  logic [arb_pkg::num_req-1:0]                     req_write,
    input  logic [arb_pkg::num_req-1:0][mem_pkg::addr_w-1:0] req_addr,
    input  logic [arb_pkg::num_req-1:0][mem_pkg::line_w-1:0] req_wdata,
    input  logic                                            read_done,
    input  logic                                            write_done,
    input  logic [mem_pkg::line_w-1:0]                      fill_line,
    output logic                                            start_read,
    output logic                                            start_write,
    output logic [mem_pkg::addr_w-1:0]                      sel_addr,
    output logic [mem_pkg::line_w-1:0]                      sel_wdata,
    output logic [arb_pkg::num_req-1:0]                     resp,
    output logic [arb_pkg::num_req-1:0][mem_pkg::line_w-1:0] rdata
);
    import mem_pkg::*;
    import arb_pkg::*;

    arb_state_t state;

    // requester currently owning the port
    req_id_t grant_id;

    // requester looked at in this poll cycle
    req_id_t poll_id;
    logic    polling;
    logic    pending;

    // requester after the one last served
    req_id_t next_id;

    // either engine finished the burst
    logic    serv_done;

    assign polling   = (state != servicing);
    assign poll_id   = req_id_t'(state[1:0]);
    assign pending   = req_read[poll_id] | req_write[poll_id];
    assign next_id   = req_id_t'(grant_id + 2'd1);
    assign serv_done = (state == servicing) && (read_done | write_done);

    // launch straight from the poll cycle
    // engines register address and line themselves
    // write wins if a data cache raises both
    assign start_write = polling & req_write[poll_id];
    assign start_read  = polling & req_read[poll_id] & ~req_write[poll_id];
    assign sel_addr    = req_addr[poll_id];
    assign sel_wdata   = req_wdata[poll_id];

    always_ff @(posedge clk) begin
        if (rst) begin
            // first poll after reset goes to requester 0
            state    <= poll_ooo_icache;
            grant_id <= ooo_icache;
        end else begin
            if (polling) begin
                if (pending) begin
                    state    <= servicing;
                    grant_id <= poll_id;
                end else begin
                    // nothing here, move on to the next one
                    state <= arb_state_t'({1'b0, req_id_t'(poll_id + 2'd1)});
                end
            end else if (serv_done) begin
                // resume polling after the served requester
                state <= arb_state_t'({1'b0, next_id});
            end
        end
    end

    // route done and line back to the owner only
    always_comb begin
        for (int i = 0; i < num_req; i++) begin
            resp[i]  = 1'b0;
            rdata[i] = '0;
        end
        resp[grant_id]  = serv_done;
        rdata[grant_id] = fill_line;
    end

endmodule

// File: arb_pkg.sv
package arb_pkg;

    // requesters sharing the memory port
    localparam int num_req = 4;

    // requester numbering, also the index into the port vectors
    // 0 and 2 are instruction caches, read only
    typedef enum logic [1:0] {
        ooo_icache = 2'd0,
        ooo_dcache = 2'd1,
        ppl_icache = 2'd2,
        ppl_dcache = 2'd3
    } req_id_t;

    // scheduler states
    // poll states carry the polled requester number in the low bits
    typedef enum logic [2:0] {
        poll_ooo_icache = 3'd0,
        poll_ooo_dcache = 3'd1,
        poll_ppl_icache = 3'd2,
        poll_ppl_dcache = 3'd3,
        servicing       = 3'd4
    } arb_state_t;

endpackage

// File: mem_pkg.sv
package mem_pkg;

    // main memory port geometry
    // one burst moves a full cache line as four beats

    // byte address width on both sides
    localparam int addr_w = 32;

    // data width of one memory beat
    localparam int beat_w = 64;

    // cache line as seen by the requesters
    localparam int line_w = 256;

    // beats needed to move one line
    localparam int beats_per_line = line_w / beat_w;

    // low address bits that are zero on a line-aligned address
    // 32 bytes per line
    localparam int line_offset_w = 5;

    // counts beats 0..3 within one burst
    typedef logic [1:0] beat_cnt_t;

endpackage
